/* dispatch_golden.txt */
// ctrl(ready,recover,verified,-) vid lqCnt sqCnt iqCnt alCnt loads stores mask3 mask2 mask1 mask0
// then exp(-,-,ready,stall) updMask3 updMask2 updMask1 updMask0, all hex, lane 3 first
8_0_00_00_00_00_0_0_00_00_00_00_2_00_00_00_00
8_0_0c_00_00_00_f_0_01_02_04_08_2_01_02_04_08
8_0_0d_00_00_00_f_0_01_02_04_08_1_01_02_04_08
8_0_0e_00_00_00_5_0_10_20_40_80_2_10_20_40_80
8_0_0f_00_00_00_5_0_10_20_40_80_1_10_20_40_80
8_0_10_00_00_00_1_0_03_00_0c_30_1_03_00_0c_30
8_0_10_00_00_00_0_0_03_00_0c_30_2_03_00_0c_30
8_0_00_0c_00_00_0_f_11_22_44_88_2_11_22_44_88
8_0_00_0d_00_00_0_f_11_22_44_88_1_11_22_44_88
8_0_00_0e_00_00_c_3_f0_0f_aa_55_2_f0_0f_aa_55
8_0_00_0f_00_00_c_3_f0_0f_aa_55_1_f0_0f_aa_55
8_0_0d_10_00_00_7_8_01_01_01_01_1_01_01_01_01
8_0_0d_10_00_00_7_0_01_01_01_01_2_01_01_01_01
8_0_0e_0e_00_00_a_5_7e_e7_3c_c3_2_7e_e7_3c_c3
8_0_0e_0f_00_00_a_5_7e_e7_3c_c3_1_7e_e7_3c_c3
8_0_00_00_1c_00_0_0_00_ff_00_ff_2_00_ff_00_ff
8_0_00_00_1d_00_0_0_00_ff_00_ff_1_00_ff_00_ff
8_0_00_00_20_00_6_9_00_ff_00_ff_1_00_ff_00_ff
8_0_00_00_00_3c_0_0_80_40_20_10_2_80_40_20_10
8_0_00_00_00_3d_0_0_80_40_20_10_1_80_40_20_10
8_0_00_00_00_40_3_4_80_40_20_10_1_80_40_20_10
8_0_0e_0e_1c_3c_3_c_0f_f0_0f_f0_2_0f_f0_0f_f0
0_0_00_00_00_00_0_0_12_34_56_78_0_12_34_56_78
c_0_00_00_00_00_1_2_12_34_56_78_0_12_34_56_78
4_0_00_00_00_00_0_0_9a_bc_de_f1_0_9a_bc_de_f1
0_0_00_00_1d_00_0_0_9a_bc_de_f1_1_9a_bc_de_f1
c_0_00_00_00_3d_0_0_9a_bc_de_f1_1_9a_bc_de_f1
8_0_00_00_00_00_4_8_9a_bc_de_f1_2_9a_bc_de_f1
a_0_00_00_00_00_0_0_ff_ff_ff_ff_2_fe_fe_fe_fe
a_3_00_00_00_00_1_2_ff_0f_08_f7_2_f7_07_00_f7
a_7_00_00_00_00_0_0_80_81_7f_c3_2_00_01_7f_43
8_7_00_00_00_00_0_0_80_81_7f_c3_2_80_81_7f_c3
a_5_05_05_10_30_f_0_3c_25_20_df_2_1c_05_00_df
e_2_00_00_00_00_0_0_04_04_ff_00_0_00_00_fb_00
2_1_00_00_00_00_0_0_02_03_fd_aa_0_00_01_fd_a8
a_4_0d_00_00_00_f_0_10_11_ef_55_1_00_01_ef_45
a_6_00_00_00_00_2_1_40_ff_bf_7e_2_00_bf_bf_3e
a_1_00_00_00_00_0_0_aa_55_33_cc_2_a8_55_31_cc
a_0_00_00_00_00_8_4_01_55_33_cc_2_00_54_32_cc
0_0_00_00_00_00_0_0_00_00_00_00_0_00_00_00_00

/* dispatch.f */
+incdir+.
dispatchPkg.sv
dispatchSpaceCheck.sv
branchMaskUpdate.sv
dispatchLatch.sv
dispatchTop.sv
dispatch_assert.sv
dispatchTb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --assert --timescale 1ns/100ps
TOP       = dispatchTb
FILELIST  = dispatch.f

BUILDDIR  = obj_dir
LOG       = sim.log
FAILMSG   = === FAIL ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)

# A crashed or aborted run counts as a failure too
run: build
	./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAILMSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -F -q "$(FAILMSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILDDIR) $(LOG)

/* dispatchTb.sv */
`include "dispatch_cfg.svh"

module dispatchTb;
  timeunit 1ns;
  timeprecision 100ps;
  import dispatchPkg::*;

  localparam int NVEC           = 40;
  localparam int RESET_CYCLES   = 4;
  localparam int TIMEOUT_CYCLES = NVEC + RESET_CYCLES + 20;

  // One line of the golden file, nibble aligned
  typedef struct packed {
    logic                               renameReady;
    logic                               flagRecoverEX;
    logic                               ctrlVerified;
    logic                               ctrlPad;
    logic                               idPad;
    checkpointIdT                       verifiedId;
    logic [2:0]                         lqPad;
    lsqCntT                             lqCnt;
    logic [2:0]                         sqPad;
    lsqCntT                             sqCnt;
    logic [1:0]                         iqPad;
    iqCntT                              iqCnt;
    logic                               alPad;
    alCntT                              alCnt;
    laneFlagsT                          loadFlags;
    laneFlagsT                          storeFlags;
    branchMaskT [`DISPATCH_WIDTH-1:0]   masks;       // Lane 3 first
    logic [1:0]                         expPad;
    logic                               expReady;
    logic                               expStall;
    branchMaskT [`DISPATCH_WIDTH-1:0]   expMasks;
  } goldenVecT;

  logic                             clk;
  logic                             arstN;
  logic                             renameReady;
  logic                             flagRecoverEX;
  logic                             ctrlVerified;
  checkpointIdT                     ctrlVerifiedId;
  renamedPktT [`DISPATCH_WIDTH-1:0] lanes;
  lsqCntT                           loadQueueCnt;
  lsqCntT                           storeQueueCnt;
  iqCntT                            issueQueueCnt;
  alCntT                            activeListCnt;

  logic                             backEndReady;
  logic                             stallFrontEnd;
  branchMaskT [`DISPATCH_WIDTH-1:0] updatedMask;
  logic                             dispatchValid;
  iqPktT [`DISPATCH_WIDTH-1:0]      iqPkt;
  alPktT [`DISPATCH_WIDTH-1:0]      alPkt;
  lsqPktT [`DISPATCH_WIDTH-1:0]     lsqPkt;

  logic [$bits(goldenVecT)-1:0]     goldenMem [0:NVEC-1];
  logic [31:0]                      lfsrState;
  int                               mismatchCnt;
  int                               otherErrCnt;
  int                               cycleCnt = 0;
  logic                             prevReady;                  // Golden ready of last cycle
  iqPktT [`DISPATCH_WIDTH-1:0]      expIq;                      // Last captured group
  alPktT [`DISPATCH_WIDTH-1:0]      expAl;
  lsqPktT [`DISPATCH_WIDTH-1:0]     expLsq;

  dispatchTop uut (
    .clk                 (clk),
    .arstN_i             (arstN),
    .renameReady_i       (renameReady),
    .lanes_i             (lanes),
    .flagRecoverEX_i     (flagRecoverEX),
    .ctrlVerified_i      (ctrlVerified),
    .ctrlVerifiedId_i    (ctrlVerifiedId),
    .loadQueueCnt_i      (loadQueueCnt),
    .storeQueueCnt_i     (storeQueueCnt),
    .issueQueueCnt_i     (issueQueueCnt),
    .activeListCnt_i     (activeListCnt),
    .backEndReady_o      (backEndReady),
    .stallFrontEnd_o     (stallFrontEnd),
    .updatedBranchMask_o (updatedMask),
    .dispatchValid_o     (dispatchValid),
    .iqPkt_o             (iqPkt),
    .alPkt_o             (alPkt),
    .lsqPkt_o            (lsqPkt)
  );

  always #2 clk = ~clk;   // 4 ns period

  always @(posedge clk) begin
    cycleCnt = cycleCnt + 1;
    if (cycleCnt >= TIMEOUT_CYCLES) begin
      $display("ERROR: simulation timed out after %0d cycles", cycleCnt);
      $display("=== FAIL ===");
      $finish;
    end
  end

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32 22 2 1
  endfunction

  task automatic takeRandBits(input int n, output logic [31:0] val);
    val = '0;
    for (int b = 0; b < n; b++) begin
      lfsrState = lfsrNext(lfsrState);
      val       = {val[30:0], lfsrState[0]};
    end
  endtask

  // Golden flags and masks, random payload elsewhere
  task automatic buildLanes(input goldenVecT g, output renamedPktT [`DISPATCH_WIDTH-1:0] l);
    logic [31:0] r;
    l = '0;
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      takeRandBits(`PC_BITS, r);
      l[i].pc = r;
      takeRandBits($bits(opcodeT), r);
      l[i].opcode = r[$bits(opcodeT)-1:0];
      takeRandBits($bits(logRegT), r);
      l[i].logDest = r[$bits(logRegT)-1:0];
      takeRandBits($bits(physRegT), r);
      l[i].physDest = r[$bits(physRegT)-1:0];
      takeRandBits($bits(physRegT), r);
      l[i].oldPhysDest = r[$bits(physRegT)-1:0];
      takeRandBits(1, r);
      l[i].destValid = r[0];
      takeRandBits($bits(physRegT), r);
      l[i].physSrc1 = r[$bits(physRegT)-1:0];
      takeRandBits($bits(physRegT), r);
      l[i].physSrc2 = r[$bits(physRegT)-1:0];
      takeRandBits($bits(checkpointIdT), r);
      l[i].checkpointId = r[$bits(checkpointIdT)-1:0];
      l[i].isLoad     = g.loadFlags[i];
      l[i].isStore    = g.storeFlags[i];
      l[i].branchMask = g.masks[i];
    end
  endtask

  task automatic recordExpected(input renamedPktT [`DISPATCH_WIDTH-1:0] l,
                                input branchMaskT [`DISPATCH_WIDTH-1:0] m);
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      expIq[i].pc           = l[i].pc;
      expIq[i].opcode       = l[i].opcode;
      expIq[i].physDest     = l[i].physDest;
      expIq[i].destValid    = l[i].destValid;
      expIq[i].physSrc1     = l[i].physSrc1;
      expIq[i].physSrc2     = l[i].physSrc2;
      expIq[i].isLoad       = l[i].isLoad;
      expIq[i].isStore      = l[i].isStore;
      expIq[i].branchMask   = m[i];                 // Golden updated mask
      expIq[i].checkpointId = l[i].checkpointId;
      expAl[i].isLoad       = l[i].isLoad;
      expAl[i].isStore      = l[i].isStore;
      expAl[i].pc           = l[i].pc;
      expAl[i].logDest      = l[i].logDest;
      expAl[i].physDest     = l[i].physDest;
      expAl[i].oldPhysDest  = l[i].oldPhysDest;
      expAl[i].destValid    = l[i].destValid;
      expLsq[i].branchMask  = m[i];
      expLsq[i].isStore     = l[i].isStore;
      expLsq[i].isLoad      = l[i].isLoad;
    end
  endtask

  task automatic expectBit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0d ns: %s is %b, expected %b", $time, what, got, exp);
      mismatchCnt++;
    end
  endtask

  task automatic expectMask(input branchMaskT got, input branchMaskT exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      mismatchCnt++;
    end
  endtask

  task automatic expectIqPkt(input iqPktT got, input iqPktT exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      mismatchCnt++;
    end
  endtask

  task automatic expectAlPkt(input alPktT got, input alPktT exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      mismatchCnt++;
    end
  endtask

  task automatic expectLsqPkt(input lsqPktT got, input lsqPktT exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      mismatchCnt++;
    end
  endtask

  // Strobe follows last ready, packets hold the last capture
  task automatic verifyCapture(input logic expValid);
    expectBit(dispatchValid, expValid, "dispatchValid");
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      expectIqPkt(iqPkt[i], expIq[i], $sformatf("iqPkt lane %0d", i));
      expectAlPkt(alPkt[i], expAl[i], $sformatf("alPkt lane %0d", i));
      expectLsqPkt(lsqPkt[i], expLsq[i], $sformatf("lsqPkt lane %0d", i));
    end
  endtask

  initial begin
    goldenVecT                        g;
    renamedPktT [`DISPATCH_WIDTH-1:0] nextLanes;
    clk = 1'b0;
    arstN          <= 1'b0;
    renameReady    <= 1'b0;
    flagRecoverEX  <= 1'b0;
    ctrlVerified   <= 1'b0;
    ctrlVerifiedId <= '0;
    lanes          <= '0;
    loadQueueCnt   <= '0;
    storeQueueCnt  <= '0;
    issueQueueCnt  <= '0;
    activeListCnt  <= '0;
    lfsrState   = 32'h0b0d_03f7;
    mismatchCnt = 0;
    otherErrCnt = 0;
    prevReady   = 1'b0;
    expIq       = '0;
    expAl       = '0;
    expLsq      = '0;
    $readmemh("dispatch_golden.txt", goldenMem);
    for (int k = 0; k < NVEC; k++) begin
      if ($isunknown(goldenMem[k])) begin
        $display("ERROR: golden vector %0d is missing or could not be read", k);
        otherErrCnt++;
      end
    end
    repeat (RESET_CYCLES) @(posedge clk);
    arstN <= 1'b1;
    for (int k = 0; k < NVEC; k++) begin
      @(posedge clk);
      g = goldenVecT'(goldenMem[k]);
      buildLanes(g, nextLanes);
      renameReady    <= g.renameReady;
      flagRecoverEX  <= g.flagRecoverEX;
      ctrlVerified   <= g.ctrlVerified;
      ctrlVerifiedId <= g.verifiedId;
      loadQueueCnt   <= g.lqCnt;
      storeQueueCnt  <= g.sqCnt;
      issueQueueCnt  <= g.iqCnt;
      activeListCnt  <= g.alCnt;
      lanes          <= nextLanes;
      @(negedge clk);   // Mid-cycle, inputs settled
      expectBit(backEndReady, g.expReady, $sformatf("backEndReady vector %0d", k));
      expectBit(stallFrontEnd, g.expStall, $sformatf("stallFrontEnd vector %0d", k));
      for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
        expectMask(updatedMask[i], g.expMasks[i],
                   $sformatf("updatedBranchMask lane %0d vector %0d", i, k));
      end
      verifyCapture(prevReady);
      if (g.expReady) begin
        recordExpected(nextLanes, g.expMasks);
      end
      prevReady = g.expReady;
    end
    @(posedge clk);
    renameReady   <= 1'b0;
    flagRecoverEX <= 1'b0;
    ctrlVerified  <= 1'b0;
    @(negedge clk);
    verifyCapture(prevReady);   // Last vector's group
    $display("Summary: %0d mismatches, %0d other errors", mismatchCnt, otherErrCnt);
    if (mismatchCnt == 0 && otherErrCnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* dispatch_assert.sv */
`include "dispatch_cfg.svh"

module dispatchAssert (
  input  logic                                          clk,
  input  logic                                          arstN_i,
  input  logic                                          flagRecoverEX_i,
  input  logic                                          ctrlVerified_i,
  input  dispatchPkg::checkpointIdT                     ctrlVerifiedId_i,
  input  logic                                          backEndReady_i,
  input  logic                                          stallFrontEnd_i,
  input  logic                                          dispatchValid_i,
  input  dispatchPkg::branchMaskT [`DISPATCH_WIDTH-1:0] updatedMask_i
);
  timeunit 1ns;
  timeprecision 100ps;

  logic verifiedBitSet;

  // Any lane still carrying the resolved checkpoint
  always_comb begin
    verifiedBitSet = 1'b0;
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      verifiedBitSet = verifiedBitSet | updatedMask_i[i][ctrlVerifiedId_i];
    end
  end

  recoverBlocksValid: assert property (
    @(posedge clk) disable iff (!arstN_i) flagRecoverEX_i |=> !dispatchValid_i
  ) else $error("dispatchValid high in the cycle after a recovery");

  readyOnlyWithoutStall: assert property (
    @(posedge clk) disable iff (!arstN_i) backEndReady_i |-> !stallFrontEnd_i
  ) else $error("backEndReady high while the front end is stalled");

  verifiedBitCleared: assert property (
    @(posedge clk) disable iff (!arstN_i) ctrlVerified_i |-> !verifiedBitSet
  ) else $error("verified checkpoint bit still set in an updated mask");

endmodule

bind dispatchTop dispatchAssert dispatchChecks (
  .clk              (clk),
  .arstN_i          (arstN_i),
  .flagRecoverEX_i  (flagRecoverEX_i),
  .ctrlVerified_i   (ctrlVerified_i),
  .ctrlVerifiedId_i (ctrlVerifiedId_i),
  .backEndReady_i   (backEndReady_o),
  .stallFrontEnd_i  (stallFrontEnd_o),
  .dispatchValid_i  (dispatchValid_o),
  .updatedMask_i    (updatedBranchMask_o)
);

/* dispatchTop.sv */
`include "dispatch_cfg.svh"

module dispatchTop (
  input  logic                                          clk,
  input  logic                                          arstN_i,

  // Rename side
  input  logic                                          renameReady_i,
  input  dispatchPkg::renamedPktT [`DISPATCH_WIDTH-1:0] lanes_i,

  // Branch resolution from execute
  input  logic                                          flagRecoverEX_i,
  input  logic                                          ctrlVerified_i,
  input  dispatchPkg::checkpointIdT                     ctrlVerifiedId_i,

  // Back-end occupancy
  input  dispatchPkg::lsqCntT                           loadQueueCnt_i,
  input  dispatchPkg::lsqCntT                           storeQueueCnt_i,
  input  dispatchPkg::iqCntT                            issueQueueCnt_i,
  input  dispatchPkg::alCntT                            activeListCnt_i,

  output logic                                          backEndReady_o,
  output logic                                          stallFrontEnd_o,
  output dispatchPkg::branchMaskT [`DISPATCH_WIDTH-1:0] updatedBranchMask_o,  // Back to rename regs
  output logic                                          dispatchValid_o,
  output dispatchPkg::iqPktT      [`DISPATCH_WIDTH-1:0] iqPkt_o,
  output dispatchPkg::alPktT      [`DISPATCH_WIDTH-1:0] alPkt_o,
  output dispatchPkg::lsqPktT     [`DISPATCH_WIDTH-1:0] lsqPkt_o
);

  dispatchSpaceCheck spaceCheck (
    .lanes_i         (lanes_i),
    .loadQueueCnt_i  (loadQueueCnt_i),
    .storeQueueCnt_i (storeQueueCnt_i),
    .issueQueueCnt_i (issueQueueCnt_i),
    .activeListCnt_i (activeListCnt_i),
    .stallFrontEnd_o (stallFrontEnd_o)
  );

  branchMaskUpdate maskUpdate (
    .lanes_i          (lanes_i),
    .ctrlVerified_i   (ctrlVerified_i),
    .ctrlVerifiedId_i (ctrlVerifiedId_i),
    .updatedMask_o    (updatedBranchMask_o)
  );

  dispatchLatch latch (
    .clk             (clk),
    .arstN_i         (arstN_i),
    .renameReady_i   (renameReady_i),
    .flagRecoverEX_i (flagRecoverEX_i),
    .stallFrontEnd_i (stallFrontEnd_o),
    .lanes_i         (lanes_i),
    .updatedMask_i   (updatedBranchMask_o),
    .backEndReady_o  (backEndReady_o),
    .dispatchValid_o (dispatchValid_o),
    .iqPkt_o         (iqPkt_o),
    .alPkt_o         (alPkt_o),
    .lsqPkt_o        (lsqPkt_o)
  );

endmodule

/* dispatchLatch.sv */
`include "dispatch_cfg.svh"

module dispatchLatch (
  input  logic                                          clk,
  input  logic                                          arstN_i,
  input  logic                                          renameReady_i,
  input  logic                                          flagRecoverEX_i,
  input  logic                                          stallFrontEnd_i,
  input  dispatchPkg::renamedPktT [`DISPATCH_WIDTH-1:0] lanes_i,
  input  dispatchPkg::branchMaskT [`DISPATCH_WIDTH-1:0] updatedMask_i,
  output logic                                          backEndReady_o,
  output logic                                          dispatchValid_o,
  output dispatchPkg::iqPktT      [`DISPATCH_WIDTH-1:0] iqPkt_o,
  output dispatchPkg::alPktT      [`DISPATCH_WIDTH-1:0] alPkt_o,
  output dispatchPkg::lsqPktT     [`DISPATCH_WIDTH-1:0] lsqPkt_o
);
  import dispatchPkg::*;

  logic                        dispatchGo;
  iqPktT [`DISPATCH_WIDTH-1:0]  iqNext;
  alPktT [`DISPATCH_WIDTH-1:0]  alNext;
  lsqPktT [`DISPATCH_WIDTH-1:0] lsqNext;

  // Rename has a group, room downstream, no flush in progress
  assign dispatchGo     = renameReady_i & ~stallFrontEnd_i & ~flagRecoverEX_i;
  assign backEndReady_o = dispatchGo;

  always_comb begin
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      iqNext[i].pc           = lanes_i[i].pc;
      iqNext[i].opcode       = lanes_i[i].opcode;
      iqNext[i].physDest     = lanes_i[i].physDest;
      iqNext[i].destValid    = lanes_i[i].destValid;
      iqNext[i].physSrc1     = lanes_i[i].physSrc1;
      iqNext[i].physSrc2     = lanes_i[i].physSrc2;
      iqNext[i].isLoad       = lanes_i[i].isLoad;
      iqNext[i].isStore      = lanes_i[i].isStore;
      iqNext[i].branchMask   = updatedMask_i[i];     // Not the raw rename mask
      iqNext[i].checkpointId = lanes_i[i].checkpointId;

      alNext[i].isLoad       = lanes_i[i].isLoad;
      alNext[i].isStore      = lanes_i[i].isStore;
      alNext[i].pc           = lanes_i[i].pc;
      alNext[i].logDest      = lanes_i[i].logDest;
      alNext[i].physDest     = lanes_i[i].physDest;
      alNext[i].oldPhysDest  = lanes_i[i].oldPhysDest;
      alNext[i].destValid    = lanes_i[i].destValid;

      lsqNext[i].branchMask  = updatedMask_i[i];
      lsqNext[i].isStore     = lanes_i[i].isStore;
      lsqNext[i].isLoad      = lanes_i[i].isLoad;
    end
  end

  // Valid is a one-cycle strobe per captured group
  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      dispatchValid_o <= 1'b0;
    end else begin
      dispatchValid_o <= dispatchGo;
    end
  end

  // Packets hold until the next capture
  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      iqPkt_o  <= '0;
      alPkt_o  <= '0;
      lsqPkt_o <= '0;
    end else if (dispatchGo) begin
      iqPkt_o  <= iqNext;
      alPkt_o  <= alNext;
      lsqPkt_o <= lsqNext;
    end
  end

endmodule

/* branchMaskUpdate.sv */
`include "dispatch_cfg.svh"

module branchMaskUpdate (
  input  dispatchPkg::renamedPktT [`DISPATCH_WIDTH-1:0] lanes_i,
  input  logic                                          ctrlVerified_i,
  input  dispatchPkg::checkpointIdT                     ctrlVerifiedId_i,
  output dispatchPkg::branchMaskT [`DISPATCH_WIDTH-1:0] updatedMask_o
);
  import dispatchPkg::*;

  branchMaskT clearVec;

  // One-hot of the checkpoint that just resolved correctly
  always_comb begin
    clearVec = '0;
    if (ctrlVerified_i) begin
      clearVec[ctrlVerifiedId_i] = 1'b1;
    end
  end

  // Same clear applies to every lane in the group
  always_comb begin
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      updatedMask_o[i] = lanes_i[i].branchMask & ~clearVec;
    end
  end

endmodule

/* dispatchSpaceCheck.sv */
`include "dispatch_cfg.svh"

module dispatchSpaceCheck (
  input  dispatchPkg::renamedPktT [`DISPATCH_WIDTH-1:0] lanes_i,
  input  dispatchPkg::lsqCntT                           loadQueueCnt_i,
  input  dispatchPkg::lsqCntT                           storeQueueCnt_i,
  input  dispatchPkg::iqCntT                            issueQueueCnt_i,
  input  dispatchPkg::alCntT                            activeListCnt_i,
  output logic                                          stallFrontEnd_o
);
  import dispatchPkg::*;

  // One extra bit so the sums never wrap
  typedef logic [$clog2(`DISPATCH_WIDTH):0] laneCntT;
  typedef logic [$bits(lsqCntT):0] lsqSumT;
  typedef logic [$bits(iqCntT):0] iqSumT;
  typedef logic [$bits(alCntT):0] alSumT;

  laneFlagsT loadBits;
  laneFlagsT storeBits;
  laneCntT   loadCnt;
  laneCntT   storeCnt;
  lsqSumT    loadSum;
  lsqSumT    storeSum;
  iqSumT     iqSum;
  alSumT     alSum;
  logic      loadFull;
  logic      storeFull;
  logic      iqFull;
  logic      alFull;

  always_comb begin
    loadCnt  = '0;
    storeCnt = '0;
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      loadBits[i]  = lanes_i[i].isLoad;
      storeBits[i] = lanes_i[i].isStore;   // Each lane's own store bit
      loadCnt      = loadCnt + laneCntT'(loadBits[i]);
      storeCnt     = storeCnt + laneCntT'(storeBits[i]);
    end
  end

  assign loadSum  = lsqSumT'(loadQueueCnt_i) + lsqSumT'(loadCnt);
  assign storeSum = lsqSumT'(storeQueueCnt_i) + lsqSumT'(storeCnt);
  assign iqSum    = iqSumT'(issueQueueCnt_i) + iqSumT'(`DISPATCH_WIDTH);
  assign alSum    = alSumT'(activeListCnt_i) + alSumT'(`DISPATCH_WIDTH);

  // Whole group must fit or nothing goes
  assign loadFull  = loadSum > lsqSumT'(`LSQ_SIZE);
  assign storeFull = storeSum > lsqSumT'(`LSQ_SIZE);
  assign iqFull    = iqSum > iqSumT'(`ISSUEQ_SIZE);
  assign alFull    = alSum > alSumT'(`ACTIVELIST_SIZE);

  assign stallFrontEnd_o = loadFull | storeFull | iqFull | alFull;

endmodule

/* dispatchPkg.sv */
`include "dispatch_cfg.svh"

package dispatchPkg;

  typedef logic [`PC_BITS-1:0] pcT;
  typedef logic [`OPCODE_BITS-1:0] opcodeT;
  typedef logic [$clog2(`LOG_REGS)-1:0] logRegT;            // 5 bits
  typedef logic [$clog2(`PHYS_REGS)-1:0] physRegT;          // 7 bits
  typedef logic [`CHECKPOINTS-1:0] branchMaskT;             // One bit per checkpoint
  typedef logic [$clog2(`CHECKPOINTS)-1:0] checkpointIdT;   // 3 bits
  typedef logic [$clog2(`LSQ_SIZE):0] lsqCntT;              // Holds 0 to LSQ_SIZE
  typedef logic [$clog2(`ISSUEQ_SIZE):0] iqCntT;
  typedef logic [$clog2(`ACTIVELIST_SIZE):0] alCntT;
  typedef logic [`DISPATCH_WIDTH-1:0] laneFlagsT;           // One bit per lane

  // Instruction as it leaves rename
  typedef struct packed {
    pcT           pc;
    opcodeT       opcode;
    logRegT       logDest;
    physRegT      physDest;
    physRegT      oldPhysDest;   // Freed when this one retires
    logic         destValid;
    physRegT      physSrc1;
    physRegT      physSrc2;
    logic         isLoad;
    logic         isStore;
    branchMaskT   branchMask;
    checkpointIdT checkpointId;
  } renamedPktT;

  typedef struct packed {
    pcT           pc;
    opcodeT       opcode;
    physRegT      physDest;
    logic         destValid;
    physRegT      physSrc1;
    physRegT      physSrc2;
    logic         isLoad;
    logic         isStore;
    branchMaskT   branchMask;    // Already cleared of the verified bit
    checkpointIdT checkpointId;
  } iqPktT;

  typedef struct packed {
    logic    isLoad;
    logic    isStore;
    pcT      pc;
    logRegT  logDest;
    physRegT physDest;
    physRegT oldPhysDest;
    logic    destValid;
  } alPktT;

  typedef struct packed {
    branchMaskT branchMask;
    logic       isStore;
    logic       isLoad;
  } lsqPktT;

endpackage

/* dispatch_cfg.svh */
`ifndef DISPATCH_CFG_SVH
`define DISPATCH_CFG_SVH

// Lanes renamed and dispatched per cycle
`define DISPATCH_WIDTH 4

// Back-end structure capacities in entries
`define LSQ_SIZE 16
`define ISSUEQ_SIZE 32
`define ACTIVELIST_SIZE 64

// Branch checkpoints in flight
`define CHECKPOINTS 8

// Register file sizes
`define PHYS_REGS 96
`define LOG_REGS 32

// Instruction word fields
`define PC_BITS 32
`define OPCODE_BITS 8

`endif
